/* bank_return.sv */
// ----------------------------------------
// Bank return path
// Merges the bank responses into one
// registered bus response
// ----------------------------------------

module bank_return #(
    parameter int BANK_COUNT = 4
) (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  mem_bus_pkg::bus_rsp_t rsp_i [BANK_COUNT],
    output mem_bus_pkg::bus_rsp_t rsp_o
);
    import mem_bus_pkg::*;

    logic                  any_ack;
    logic [DATA_WIDTH-1:0] hit_data;
    logic                  ack_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    // At most one bank acks at a time
    always_comb begin
        any_ack  = 1'b0;
        hit_data = '0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            if (rsp_i[i].ack) begin
                any_ack  = 1'b1;
                hit_data = rsp_i[i].rdata;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= any_ack;
        end
    end

    always_ff @(posedge clock) begin
        if (any_ack) begin
            rdata_q <= hit_data;               // Hold between acks
        end
    end

    assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

/* bank_select.sv */
// ----------------------------------------
// Bank selector
// Registers the bus request and issues one
// bank strobe per bus cycle
// ----------------------------------------

module bank_select #(
    parameter int BANK_COUNT      = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                       clock,
    input  logic                       rst_n_i,
    input  mem_bus_pkg::bus_req_t      bus_req_i,
    output logic [BANK_COUNT-1:0]      sel_o,
    output logic [BANK_ADDR_WIDTH-1:0] offset_o,
    output logic [7:0]                 wdata_o,
    output logic                       we_o
);
    import mem_bus_pkg::*;

    localparam int BANK_BITS = $clog2(BANK_COUNT);

    logic [BANK_BITS-1:0]       bank_idx;
    logic [BANK_COUNT-1:0]      sel_q;
    logic                       issued_q;     // Strobe already sent this cycle
    logic [BANK_ADDR_WIDTH-1:0] offset_q;
    logic [DATA_WIDTH-1:0]      wdata_q;
    logic                       we_q;

    // Bank from the top address bits
    assign bank_idx = bus_req_i.addr[ADDR_WIDTH-1 -: BANK_BITS];

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            sel_q    <= '0;
            issued_q <= 1'b0;
        end else begin
            sel_q <= '0;                       // Single-clock strobe
            if (bus_req_i.cycle && !issued_q) begin
                sel_q    <= BANK_COUNT'(1) << bank_idx;
                issued_q <= 1'b1;
            end else if (!bus_req_i.cycle) begin
                issued_q <= 1'b0;              // Rearm once cycle drops
            end
        end
    end

    always_ff @(posedge clock) begin
        offset_q <= bus_req_i.addr[BANK_ADDR_WIDTH-1:0];
        wdata_q  <= bus_req_i.wdata;
        we_q     <= bus_req_i.we;
    end

    assign sel_o    = sel_q;
    assign offset_o = offset_q;
    assign wdata_o  = wdata_q;
    assign we_o     = we_q;

endmodule

/* mem_bus_pkg.sv */
// ----------------------------------------
// Memory bus definitions
// Request and response records shared by
// the controller, selector and banks
// ----------------------------------------

package mem_bus_pkg;

    localparam int ADDR_WIDTH = 20;       // Byte-addressed space
    localparam int DATA_WIDTH = 8;        // One byte per cycle

    // Controller to memory
    typedef struct packed {
        logic                  cycle;     // Held until ack
        logic                  we;        // 1 = write
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } bus_req_t;

    // Memory to controller
    typedef struct packed {
        logic                  ack;       // One clock wide
        logic [DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

endpackage

/* ram_bank.sv */
// ----------------------------------------
// Byte-wide RAM bank
// Acks each strobe one clock later with
// registered read data
// ----------------------------------------

module ram_bank #(
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                       clock,
    input  logic                       rst_n_i,
    input  logic                       sel_i,
    input  logic                       we_i,
    input  logic [BANK_ADDR_WIDTH-1:0] offset_i,
    input  logic [7:0]                 wdata_i,
    output mem_bus_pkg::bus_rsp_t      rsp_o
);
    import mem_bus_pkg::*;

    localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  ack_q;

    always_ff @(posedge clock) begin
        if (sel_i) begin
            if (we_i) begin
                mem_q[offset_i] <= wdata_i;
                rdata_q         <= wdata_i;    // Write-through
            end else begin
                rdata_q <= mem_q[offset_i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel_i;                    // Strobe is one clock, so is ack
        end
    end

    assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

/* spi_bridge_props.sv */
// ----------------------------------------
// Bus cycle and stall properties
// Bound into the SPI bus controller
// ----------------------------------------

module spi_bridge_props (
    input logic                  clock,
    input logic                  rst_n_i,
    input mem_bus_pkg::bus_req_t bus_req_i,
    input mem_bus_pkg::bus_rsp_t bus_rsp_i,
    input logic                  stall_i,
    input logic                  cs_rise_i
);
    int fail_count = 0;    // Failed assertion count

    ack_ends_cycle: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        bus_rsp_i.ack |=> !bus_req_i.cycle
    ) else begin
        fail_count++;
        $error("cycle still high on the clock after ack");
    end

    stall_covers_cycle: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        bus_req_i.cycle |-> stall_i
    ) else begin
        fail_count++;
        $error("cycle high while stall is low");
    end

    addr_stable_in_cycle: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        bus_req_i.cycle |=> !bus_req_i.cycle || $stable(bus_req_i.addr)
    ) else begin
        fail_count++;
        $error("address changed during a bus cycle");
    end

    abort_drops_cycle: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        cs_rise_i |=> !bus_req_i.cycle
    ) else begin
        fail_count++;
        $error("cycle still high after chip select rose");
    end

endmodule

/* spi_bridge_tb.sv */
// ----------------------------------------
// Testbench for the SPI to memory bridge
// Replays the trace file, then seeded
// random traffic, against a byte model
// ----------------------------------------

module spi_bridge_tb;
    import spi_proto_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int HALF_BIT        = 4;      // Clocks per SCK phase
    localparam int CS_GAP          = 8;      // Clocks with chip select high
    localparam int STALL_LIMIT     = 64;
    localparam int CLOCKS_PER_OP   = 400;
    localparam int RANDOM_OPS      = 40;
    localparam int RANDOM_SEED     = 25;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int BANK_DEPTH      = 2 ** BANK_ADDR_WIDTH;
    localparam int MODEL_CELLS     = 4 * BANK_DEPTH;

    logic clock;
    logic rst_n;
    logic sck;
    logic cs_n;
    logic pico;
    logic poci;
    logic stall;

    // Reference model, one cell per bank and offset
    logic [7:0]  model_mem [MODEL_CELLS];
    bit          model_written [MODEL_CELLS];
    logic [19:0] last_addr;
    logic [19:0] written_addrs [$];

    byte         trace_op [$];
    logic [19:0] trace_addr [$];
    logic [7:0]  trace_data [$];
    bit          trace_loaded;

    spi_bridge_top uut (
        .clock       (clock),
        .rst_n_i     (rst_n),
        .spi_sck_i   (sck),
        .spi_cs_n_i  (cs_n),
        .spi_pico_i  (pico),
        .spi_poci_o  (poci),
        .spi_stall_o (stall)
    );

    bind spi_bus_controller spi_bridge_props props (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req_o),
        .bus_rsp_i (bus_rsp_i),
        .stall_i   (spi_stall_o),
        .cs_rise_i (cs_rise)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clock) begin
        if (uut.controller.props.fail_count != 0) begin
            stop_run("a bus assertion failed during the run");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                               name, got, exp));
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clock);
        #DRIVE_DELAY;
    endtask

    // Bank from the top two bits, offset from the low bits
    function automatic int cell_of(input logic [19:0] addr);
        return int'(addr[19:18]) * BANK_DEPTH + int'(addr[BANK_ADDR_WIDTH-1:0]);
    endfunction

    function automatic logic [7:0] model_read(input logic [19:0] addr);
        if (model_written[cell_of(addr)]) begin
            return model_mem[cell_of(addr)];
        end
        return 8'h00;                            // Never written
    endfunction

    task automatic model_write(input logic [19:0] addr, input logic [7:0] data);
        model_mem[cell_of(addr)]     = data;
        model_written[cell_of(addr)] = 1'b1;
        written_addrs.push_back(addr);
        last_addr = addr;
    endtask

    // Mode 0, MSB first, top count bits of tx
    task automatic spi_shift(input logic [7:0] tx, input int count,
                             output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i > 7 - count; i--) begin
            pico = tx[i];
            step(HALF_BIT);
            rx[i] = poci;                        // Sampled at the rising edge
            sck   = 1'b1;
            step(HALF_BIT);
            sck   = 1'b0;
        end
    endtask

    task automatic frame_begin();
        cs_n = 1'b0;
        step(HALF_BIT);
    endtask

    task automatic frame_end();
        cs_n = 1'b1;
        pico = 1'b0;
        step(CS_GAP);
        check_value("spi_stall_o", stall, 0);
    endtask

    task automatic wait_stall_low();
        int waited;
        waited = 0;
        while (stall) begin
            if (waited == STALL_LIMIT) begin
                stop_run("stall stayed high, the bus cycle never completed");
            end
            step(1);
            waited++;
        end
    endtask

    task automatic send_header(input spi_op_e op, input logic [19:0] addr);
        logic [7:0] unused;
        spi_shift({op, 1'b0, addr[19:16]}, 8, unused);
        if (op != OP_READ_NEXT) begin
            spi_shift(addr[15:8], 8, unused);
            spi_shift(addr[7:0], 8, unused);
        end
    endtask

    task automatic write_at(input logic [19:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        frame_begin();
        send_header(OP_WRITE_AT, addr);
        spi_shift(data, 8, unused);
        wait_stall_low();                        // Raising CS early would abort
        frame_end();
        model_write(addr, data);
    endtask

    // Half a data byte, then chip select rises
    task automatic aborted_write(input logic [19:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        frame_begin();
        send_header(OP_WRITE_AT, addr);
        spi_shift(data, 4, unused);
        frame_end();
        last_addr = addr;                        // Address bytes already taken
    endtask

    task automatic read_byte(input spi_op_e op, input logic [19:0] addr,
                             output logic [7:0] data);
        frame_begin();
        send_header(op, addr);
        wait_stall_low();
        spi_shift(8'h00, 8, data);               // Dummy byte clocks the reply
        frame_end();
    endtask

    task automatic checked_read(input spi_op_e op, input logic [19:0] addr);
        logic [7:0] got;
        read_byte(op, addr, got);
        check_value("spi_poci_o", got, model_read(addr));
        last_addr = addr;
    endtask

    task automatic load_trace();
        int          fd;
        int          fields;
        string       line;
        string       op_text;
        logic [19:0] addr;
        logic [7:0]  data;
        fd = $fopen("spi_bridge_trace.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the trace file spi_bridge_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h", op_text, addr, data);
            if (fields != 3) begin
                stop_run({"malformed trace line: ", line});
            end
            trace_op.push_back(op_text[0]);
            trace_addr.push_back(addr);
            trace_data.push_back(data);
        end
        $fclose(fd);
        trace_loaded = 1'b1;
    endtask

    task automatic replay_line(input byte op, input logic [19:0] addr,
                               input logic [7:0] data);
        case (op)
            "W": write_at(addr, data);
            "A": aborted_write(addr, data);
            "R": begin
                check_value("trace_data", data, model_read(addr));
                checked_read(OP_READ_AT, addr);
            end
            "N": begin
                // Trace names the address that read-next should reach
                check_value("trace_addr", addr, 20'(last_addr + 20'd1));
                check_value("trace_data", data, model_read(addr));
                checked_read(OP_READ_NEXT, addr);
            end
            default: stop_run($sformatf("unknown trace opcode %c", op));
        endcase
    endtask

    task automatic random_traffic();
        logic [19:0] addr;
        int          kind;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            kind = $urandom_range(2, 0);
            if (written_addrs.size() == 0) begin
                kind = 0;
            end
            if (kind == 2 && !model_written[cell_of(20'(last_addr + 20'd1))]) begin
                kind = 1;
            end
            case (kind)
                0: write_at(20'($urandom), 8'($urandom));
                1: begin
                    addr = written_addrs[$urandom_range(written_addrs.size() - 1, 0)];
                    addr[17:BANK_ADDR_WIDTH] = 12'($urandom);     // Aliased address
                    checked_read(OP_READ_AT, addr);
                end
                default: checked_read(OP_READ_NEXT, 20'(last_addr + 20'd1));
            endcase
        end
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        clock     = 1'b0;
        rst_n     = 1'b0;
        sck       = 1'b0;
        cs_n      = 1'b1;
        pico      = 1'b0;
        last_addr = '0;                          // Controller address after reset
        load_trace();
        step(3);
        rst_n = 1'b1;
        step(CS_GAP);
        for (int i = 0; i < trace_op.size(); i++) begin
            replay_line(trace_op[i], trace_addr[i], trace_data[i]);
        end
        random_traffic();
        if (uut.controller.props.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "bus assertions failed during the run");
        end
    end

    // Budget scales with the number of operations
    initial begin
        wait (trace_loaded);
        repeat ((trace_op.size() + RANDOM_OPS) * CLOCKS_PER_OP + 4 * CS_GAP) begin
            @(posedge clock);
        end
        stop_run("watchdog expired, the run did not finish in time");
    end

endmodule

/* spi_bridge_top.sv */
// ----------------------------------------
// SPI to memory bridge top level
// Controller, bank selector, RAM banks and
// the response return path
// ----------------------------------------

module spi_bridge_top #(
    parameter int BANK_COUNT      = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic clock,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);
    import mem_bus_pkg::*;

    bus_req_t                   bus_req;
    bus_rsp_t                   bus_rsp;
    bus_rsp_t                   bank_rsp [BANK_COUNT];
    logic [BANK_COUNT-1:0]      bank_sel;
    logic [BANK_ADDR_WIDTH-1:0] bank_offset;
    logic [DATA_WIDTH-1:0]      bank_wdata;
    logic                       bank_we;

    spi_bus_controller controller (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .spi_sck_i   (spi_sck_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_pico_i  (spi_pico_i),
        .spi_poci_o  (spi_poci_o),
        .spi_stall_o (spi_stall_o),
        .bus_req_o   (bus_req),
        .bus_rsp_i   (bus_rsp)
    );

    bank_select #(
        .BANK_COUNT      (BANK_COUNT),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) selector (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .sel_o     (bank_sel),
        .offset_o  (bank_offset),
        .wdata_o   (bank_wdata),
        .we_o      (bank_we)
    );

    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
        ram_bank #(
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
        ) bank (
            .clock    (clock),
            .rst_n_i  (rst_n_i),
            .sel_i    (bank_sel[g]),
            .we_i     (bank_we),
            .offset_i (bank_offset),
            .wdata_i  (bank_wdata),
            .rsp_o    (bank_rsp[g])
        );
    end

    bank_return #(
        .BANK_COUNT (BANK_COUNT)
    ) merger (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .rsp_i   (bank_rsp),
        .rsp_o   (bus_rsp)
    );

endmodule

/* spi_bridge_trace.txt */
# op addr data: W write-at, R read-at, N read-next, A write aborted after the address
# addr and data in hex; data is the write byte or the expected read byte
W 00000 11
W 00001 22
W 00002 33
R 00000 11
N 00001 22
N 00002 33
W 40005 5A
W 80005 6B
W C0005 7C
W 4FFC5 9E
R 40005 9E
R 80005 6B
R C0005 7C
R 00000 11
W FFFFF E1
R FFFFF E1
N 00000 11
A 80005 FF
R 80005 6B
W 80006 42
R 80006 42

/* spi_bus_controller.sv */
// ----------------------------------------
// SPI mode 0 command decoder and bus master
// Turns write-at, read-at and read-next
// commands into single bus cycles
// ----------------------------------------

module spi_bus_controller (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_cs_n_i,
    input  logic                  spi_pico_i,
    output logic                  spi_poci_o,
    output logic                  spi_stall_o,
    output mem_bus_pkg::bus_req_t bus_req_o,
    input  mem_bus_pkg::bus_rsp_t bus_rsp_i
);
    import spi_proto_pkg::*;
    import mem_bus_pkg::*;

    // Pin synchronizers
    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] pico_sync;
    logic       sck_prev;
    logic       cs_prev;

    logic sck_rise;
    logic sck_fall;
    logic cs_rise;
    logic cs_fall;

    ctrl_state_e state_q;
    logic [2:0]  bit_cnt_q;
    logic        byte_done;

    logic [DATA_WIDTH-1:0] shift_q;
    logic [DATA_WIDTH-1:0] next_byte;
    spi_op_e               cmd_op;

    // Bus request fields
    logic                  cycle_q;
    logic                  we_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;

    logic                  stall_q;
    logic                  poci_q;
    logic [DATA_WIDTH-1:0] out_q;     // Reply shifter

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            sck_sync  <= 2'b00;
            sck_prev  <= 1'b0;
            cs_sync   <= 2'b11;           // Deselected
            cs_prev   <= 1'b1;
            pico_sync <= 2'b00;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_sync   <= {cs_sync[0], spi_cs_n_i};
            pico_sync <= {pico_sync[0], spi_pico_i};
            sck_prev  <= sck_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign sck_fall = ~sck_sync[1] & sck_prev;
    assign cs_rise  = cs_sync[1] & ~cs_prev;
    assign cs_fall  = ~cs_sync[1] & cs_prev;

    // MSB first, PICO delayed like SCK so they stay aligned
    assign next_byte = {shift_q[DATA_WIDTH-2:0], pico_sync[1]};
    assign cmd_op    = spi_op_e'(next_byte[CMD_OP_LSB +: 3]);
    assign byte_done = sck_rise && (bit_cnt_q == 3'd7);

    always_ff @(posedge clock) begin
        if (sck_rise) begin
            shift_q <= next_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            cycle_q   <= 1'b0;
            stall_q   <= 1'b0;
            poci_q    <= 1'b0;
            addr_q    <= '0;
        end else if (cs_sync[1]) begin
            // Deselected or aborted, drop everything
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            cycle_q   <= 1'b0;
            stall_q   <= 1'b0;
            poci_q    <= 1'b0;
        end else begin
            // Bits clocked while stalled are ignored
            if (sck_rise && state_q != IDLE && state_q != BUS) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end

            case (state_q)
                IDLE: begin
                    if (cs_fall) begin
                        state_q   <= CMD;
                        bit_cnt_q <= '0;
                    end
                end
                CMD: begin
                    if (byte_done) begin
                        case (cmd_op)
                            OP_WRITE_AT: begin
                                we_q    <= 1'b1;
                                addr_q[ADDR_WIDTH-1 -: CMD_ADDR_BITS] <=
                                    next_byte[CMD_ADDR_BITS-1:0];
                                state_q <= ADDR_HI;
                            end
                            OP_READ_AT: begin
                                we_q    <= 1'b0;
                                addr_q[ADDR_WIDTH-1 -: CMD_ADDR_BITS] <=
                                    next_byte[CMD_ADDR_BITS-1:0];
                                state_q <= ADDR_HI;
                            end
                            OP_READ_NEXT: begin
                                we_q    <= 1'b0;
                                addr_q  <= addr_q + 1'b1;     // Wraps at 20 bits
                                cycle_q <= 1'b1;
                                stall_q <= 1'b1;
                                state_q <= BUS;
                            end
                            default: state_q <= IDLE;         // Unknown opcode
                        endcase
                    end
                end
                ADDR_HI: begin
                    if (byte_done) begin
                        addr_q[15:8] <= next_byte;
                        state_q      <= ADDR_LO;
                    end
                end
                ADDR_LO: begin
                    if (byte_done) begin
                        addr_q[7:0] <= next_byte;
                        if (we_q) begin
                            state_q <= DATA;
                        end else begin
                            cycle_q <= 1'b1;
                            stall_q <= 1'b1;
                            state_q <= BUS;
                        end
                    end
                end
                DATA: begin
                    if (byte_done) begin
                        wdata_q <= next_byte;
                        cycle_q <= 1'b1;
                        stall_q <= 1'b1;
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    if (bus_rsp_i.ack) begin
                        cycle_q <= 1'b0;
                        stall_q <= 1'b0;
                        if (we_q) begin
                            state_q <= IDLE;
                        end else begin
                            // First bit must be ready before the first SCK rise
                            poci_q  <= bus_rsp_i.rdata[DATA_WIDTH-1];
                            out_q   <= {bus_rsp_i.rdata[DATA_WIDTH-2:0], 1'b0};
                            state_q <= REPLY;
                        end
                    end
                end
                REPLY: begin
                    // A fall before the first reply rise belongs to the command
                    if (sck_fall && bit_cnt_q != 3'd0) begin
                        poci_q <= out_q[DATA_WIDTH-1];
                        out_q  <= {out_q[DATA_WIDTH-2:0], 1'b0};
                    end
                    if (byte_done) begin
                        poci_q  <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign bus_req_o   = '{cycle: cycle_q, we: we_q, addr: addr_q, wdata: wdata_q};
    assign spi_stall_o = stall_q;
    assign spi_poci_o  = poci_q;

endmodule

/* spi_proto_pkg.sv */
// ----------------------------------------
// SPI protocol definitions for the bridge
// Command opcodes, controller states and
// the layout of the command byte
// ----------------------------------------

package spi_proto_pkg;

    // Opcode sits in the top three bits of the command byte
    typedef enum logic [2:0] {
        OP_READ_NEXT = 3'b001,    // Last address plus one
        OP_READ_AT   = 3'b011,    // Explicit 20-bit address
        OP_WRITE_AT  = 3'b100     // Explicit address, then data
    } spi_op_e;

    typedef enum logic [2:0] {
        IDLE,                     // Waiting for chip select to fall
        CMD,                      // Shifting in the command byte
        ADDR_HI,                  // Address bits [15:8]
        ADDR_LO,                  // Address bits [7:0]
        DATA,                     // Write data byte
        BUS,                      // Bus cycle pending, stall high
        REPLY                     // Read data out on POCI
    } ctrl_state_e;

    // Address bits [19:16] ride in the low nibble
    localparam int CMD_ADDR_BITS = 4;

    // Bit position of the opcode field's LSB
    localparam int CMD_OP_LSB = 5;

endpackage

/* verilog.f */
spi_proto_pkg.sv
mem_bus_pkg.sv
spi_bus_controller.sv
bank_select.sv
ram_bank.sv
bank_return.sv
spi_bridge_top.sv
spi_bridge_props.sv
spi_bridge_tb.sv
